/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_cpu_core
FLIST = verilog.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* common/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN         32
`define REG_ADDR_W   5
`define NUM_REGS     32
`define IMM_W        16
`define OPC_W        6
`define WINDOW_SLOTS 3
`define ISSUE_LANES  2

// register-register ops
`define OPC_ADD  6'h01
`define OPC_SUB  6'h02
`define OPC_AND  6'h03
`define OPC_OR   6'h04
`define OPC_XOR  6'h05
`define OPC_SLT  6'h06
// immediate ops
`define OPC_ADDI 6'h08
`define OPC_ORI  6'h09
`define OPC_LUI  6'h0a

`endif

/* common/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

	typedef struct packed {
		logic [`OPC_W-1:0]                          opc;
		logic [`REG_ADDR_W-1:0]                     rd;
		logic [`REG_ADDR_W-1:0]                     rs1;
		logic [`REG_ADDR_W-1:0]                     rs2;
		logic [`XLEN-`OPC_W-3*`REG_ADDR_W-1:0]      unused;
	} r_fmt_t;

	typedef struct packed {
		logic [`OPC_W-1:0]      opc;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`IMM_W-1:0]      imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// second operand comes from the immediate field
	function automatic logic opc_is_imm(input logic [`OPC_W-1:0] opc);
		return (opc == `OPC_ADDI) || (opc == `OPC_ORI) || (opc == `OPC_LUI);
	endfunction

endpackage

/* common/decoded_if.sv */
`timescale 1ns/10ps
`include "core_config.svh"

interface decoded_if import core_pkg::*; ();

	// slot 0 is the older instruction
	logic [`ISSUE_LANES-1:0] vld;
	instr_t                  instr [`ISSUE_LANES];
	logic                    busy;

	modport dec (
		output vld,
		output instr,
		input  busy
	);

	modport win (
		input  vld,
		input  instr,
		output busy
	);

endinterface

/* common/issue_if.sv */
`timescale 1ns/10ps
`include "core_config.svh"

interface issue_if import core_pkg::*; ();

	logic                   vld;
	instr_t                 instr;
	// zero when nothing is written
	logic [`REG_ADDR_W-1:0] dest;

	modport win (
		output vld,
		output instr,
		output dest
	);

	modport lane (
		input vld,
		input instr,
		input dest
	);

endinterface

/* decode/pair_decoder.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module pair_decoder import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_pair_vld,
	input  logic [2*`XLEN-1:0]    i_pair,
	output logic                  o_pair_rdy,
	decoded_if.dec                dec
);

	instr_t in_word [`ISSUE_LANES];

	function automatic logic opc_valid(input logic [`OPC_W-1:0] opc);
		case (opc)
			`OPC_ADD, `OPC_SUB, `OPC_AND, `OPC_OR, `OPC_XOR, `OPC_SLT,
			`OPC_ADDI, `OPC_ORI, `OPC_LUI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// upper word is the older instruction
	always_comb begin
		for (int d = 0; d < `ISSUE_LANES; d++) begin
			in_word[d] = i_pair[(`ISSUE_LANES-1-d)*`XLEN +: `XLEN];
		end
	end

	assign o_pair_rdy = ~dec.busy;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec.vld <= '0;
		end else if (!dec.busy) begin
			for (int d = 0; d < `ISSUE_LANES; d++) begin
				dec.vld[d] <= i_pair_vld && opc_valid(in_word[d].r.opc);
			end
		end
	end

	// hold the pair while the window is full
	always_ff @(posedge clk) begin
		if (!dec.busy) begin
			dec.instr <= in_word;
		end
	end

endmodule

/* dv/tb_programs.svh */
// reference model state kept across tests like the register file
logic [`XLEN-1:0]     model_reg [`NUM_REGS];
logic [`NUM_REGS-1:0] model_set;
int                   exp_count;

// flat pair list with the older instruction in the upper word
logic [2*`XLEN-1:0] pair_q [$];
string              test_name [$];
int                 test_first [$];
int                 test_len [$];
bit                 test_rand [$];

function automatic logic [`XLEN-1:0] make_r(input logic [`OPC_W-1:0] opc, input int rd,
		input int rs1, input int rs2);
	instr_t w;
	w = '0;
	w.r.opc = opc;
	w.r.rd = rd[`REG_ADDR_W-1:0];
	w.r.rs1 = rs1[`REG_ADDR_W-1:0];
	w.r.rs2 = rs2[`REG_ADDR_W-1:0];
	return w;
endfunction

function automatic logic [`XLEN-1:0] make_i(input logic [`OPC_W-1:0] opc, input int rd,
		input int rs, input logic [`IMM_W-1:0] imm);
	instr_t w;
	w.i.opc = opc;
	w.i.rd = rd[`REG_ADDR_W-1:0];
	w.i.rs = rs[`REG_ADDR_W-1:0];
	w.i.imm = imm;
	return w;
endfunction

task automatic new_test(input string name, input bit rand_gaps);
	test_name.push_back(name);
	test_first.push_back(pair_q.size());
	test_len.push_back(0);
	test_rand.push_back(rand_gaps);
endtask

task automatic add_pair(input logic [`XLEN-1:0] older, input logic [`XLEN-1:0] younger);
	pair_q.push_back({older, younger});
	test_len[test_len.size()-1]++;
endtask

task automatic load_programs();
	model_set = '0;
	new_test("all_ops", 1'b0);
	add_pair(make_i(`OPC_ADDI, 1, 0, 16'h0005), make_i(`OPC_ADDI, 2, 0, 16'hfffd));
	add_pair(make_i(`OPC_LUI, 3, 0, 16'h1234), make_i(`OPC_ORI, 4, 0, 16'h8001));
	add_pair(make_i(`OPC_ORI, 5, 0, 16'h0ff0), make_i(`OPC_ADDI, 6, 0, 16'h0123));
	add_pair(make_r(`OPC_ADD, 7, 1, 2), make_r(`OPC_SUB, 8, 1, 2));
	add_pair(make_r(`OPC_AND, 9, 5, 6), make_r(`OPC_OR, 10, 5, 6));
	add_pair(make_r(`OPC_XOR, 11, 3, 4), make_r(`OPC_SLT, 12, 2, 1));
	add_pair(make_r(`OPC_SLT, 13, 1, 2), make_r(`OPC_ADD, 0, 1, 1));
	// dependent inside a pair and across pairs
	new_test("raw_chain", 1'b1);
	add_pair(make_i(`OPC_ADDI, 14, 1, 16'h0001), make_r(`OPC_ADD, 15, 14, 14));
	add_pair(make_r(`OPC_SUB, 16, 15, 1), make_r(`OPC_XOR, 17, 16, 15));
	add_pair(make_i(`OPC_ADDI, 14, 14, 16'h0010), make_r(`OPC_ADD, 18, 14, 17));
	add_pair(make_r(`OPC_OR, 19, 18, 0), make_i(`OPC_ADDI, 20, 19, 16'hffff));
	new_test("waw_war_r0", 1'b0);
	add_pair(make_i(`OPC_ADDI, 21, 0, 16'h0007), make_i(`OPC_ADDI, 21, 0, 16'h0009));
	add_pair(make_r(`OPC_ADD, 22, 21, 1), make_i(`OPC_ADDI, 21, 0, 16'h0055));
	add_pair(make_r(`OPC_ADD, 23, 0, 0), make_i(`OPC_ORI, 24, 0, 16'h0000));
	// 0x3f and 0x00 are not opcodes
	add_pair(make_i(6'h3f, 25, 1, 16'h0000), make_i(`OPC_ADDI, 26, 21, 16'h0001));
	add_pair(make_r(6'h00, 25, 1, 2), make_r(`OPC_SUB, 22, 22, 1));
	add_pair(make_i(`OPC_ADDI, 0, 5, 16'h0003), make_r(`OPC_XOR, 0, 1, 2));
	// held valid with dense hazards keeps the window full
	new_test("stream", 1'b0);
	add_pair(make_i(`OPC_ADDI, 27, 0, 16'h0100), make_i(`OPC_ADDI, 28, 0, 16'h0200));
	add_pair(make_i(`OPC_ADDI, 29, 0, 16'h0300), make_i(`OPC_LUI, 30, 0, 16'h0040));
	add_pair(make_i(`OPC_ORI, 31, 0, 16'h0f0f), make_r(`OPC_SLT, 26, 2, 0));
	for (int k = 0; k < 16; k++) begin
		add_pair(make_i(`OPC_ADDI, 27 + k % 5, 27 + (k + 2) % 5, 16'(k + 1)),
			make_r(`OPC_ADD, 27 + (k + 3) % 5, 27 + k % 5, 1 + k % 6));
	end
endtask

// executes one word in program order
task automatic model_exec(input logic [`XLEN-1:0] word);
	instr_t            w;
	logic [`XLEN-1:0]  a;
	logic [`XLEN-1:0]  b;
	logic [`XLEN-1:0]  res;
	logic [`IMM_W-1:0] imm;
	bit                ok;
	w = word;
	imm = w.i.imm;
	a = (w.r.rs1 == '0) ? '0 : model_reg[w.r.rs1];
	b = (w.r.rs2 == '0) ? '0 : model_reg[w.r.rs2];
	ok = 1'b1;
	case (w.r.opc)
		`OPC_ADD:  res = a + b;
		`OPC_SUB:  res = a - b;
		`OPC_AND:  res = a & b;
		`OPC_OR:   res = a | b;
		`OPC_XOR:  res = a ^ b;
		`OPC_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		`OPC_ADDI: res = a + {{16{imm[15]}}, imm};
		`OPC_ORI:  res = a | {16'h0000, imm};
		`OPC_LUI:  res = {imm, 16'h0000};
		default: begin
			res = '0;
			ok = 1'b0;
		end
	endcase
	if (ok && w.r.rd != '0) begin
		model_reg[w.r.rd] = res;
		model_set[w.r.rd] = 1'b1;
		exp_count++;
	end
endtask

/* dv/tb_cpu_core.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module tb_cpu_core import core_pkg::*; ();

	logic                   clk;
	logic                   rstn;
	logic                   i_pair_vld;
	logic [2*`XLEN-1:0]     i_pair;
	logic                   o_pair_rdy;
	logic                   o_wb0_vld;
	logic [`REG_ADDR_W-1:0] o_wb0_addr;
	logic [`XLEN-1:0]       o_wb0_data;
	logic                   o_wb1_vld;
	logic [`REG_ADDR_W-1:0] o_wb1_addr;
	logic [`XLEN-1:0]       o_wb1_data;

	int                   errors;
	int                   checks;
	int                   wb_count;
	int                   seed;
	bit                   loaded = 1'b0;
	string                cur_test;
	logic [`XLEN-1:0]     shadow_reg [`NUM_REGS];
	logic [`NUM_REGS-1:0] shadow_set;

	`include "tb_programs.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	cpu_core dut0 (
		.clk        (clk),
		.rstn       (rstn),
		.o_pair_rdy (o_pair_rdy),
		.i_pair_vld (i_pair_vld),
		.i_pair     (i_pair),
		.o_wb0_vld  (o_wb0_vld),
		.o_wb0_addr (o_wb0_addr),
		.o_wb0_data (o_wb0_data),
		.o_wb1_vld  (o_wb1_vld),
		.o_wb1_addr (o_wb1_addr),
		.o_wb1_data (o_wb1_data)
	);

	task check_value(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error in %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task record_wb(input logic vld, input logic [`REG_ADDR_W-1:0] addr,
			input logic [`XLEN-1:0] data);
		if (vld === 1'b1) begin
			if (addr == '0) begin
				errors++;
				$display("test %s: a writeback went to register 0", cur_test);
			end
			shadow_reg[addr] = data;
			shadow_set[addr] = 1'b1;
			wb_count++;
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (rstn) begin
			record_wb(o_wb0_vld, o_wb0_addr, o_wb0_data);
			record_wb(o_wb1_vld, o_wb1_addr, o_wb1_data);
		end
	end

	// holds the pair until an edge with ready high
	task send_pair(input logic [2*`XLEN-1:0] pair);
		logic rdy;
		i_pair_vld <= 1'b1;
		i_pair <= pair;
		do begin
			@(negedge clk);
			rdy = o_pair_rdy;
			@(posedge clk);
		end while (!rdy);
	endtask

	task compare_state(input string name);
		for (int r = 1; r < `NUM_REGS; r++) begin
			if (model_set[r]) begin
				check_value($sformatf("%s r%0d", name, r), model_reg[r], shadow_reg[r]);
			end
		end
		check_value({name, " written set"}, model_set, shadow_set);
		check_value({name, " writeback count"}, exp_count, wb_count);
	endtask

	task run_test(input int t);
		int               gap;
		logic [2*`XLEN-1:0] pair;
		cur_test = test_name[t];
		wb_count = 0;
		exp_count = 0;
		for (int p = 0; p < test_len[t]; p++) begin
			pair = pair_q[test_first[t] + p];
			model_exec(pair[2*`XLEN-1:`XLEN]);
			model_exec(pair[`XLEN-1:0]);
		end
		for (int p = 0; p < test_len[t]; p++) begin
			send_pair(pair_q[test_first[t] + p]);
			if (test_rand[t]) begin
				gap = $unsigned($random(seed)) % 4;
				if (gap > 0) begin
					i_pair_vld <= 1'b0;
					repeat (gap) @(posedge clk);
				end
			end
		end
		i_pair_vld <= 1'b0;
		while (wb_count < exp_count) begin
			@(posedge clk);
		end
		// room for any stray or duplicate writeback
		repeat (8) @(posedge clk);
		compare_state(test_name[t]);
	endtask

	initial begin
		seed = 63394;
		rstn = 1'b0;
		i_pair_vld = 1'b0;
		i_pair = '0;
		errors = 0;
		checks = 0;
		wb_count = 0;
		shadow_set = '0;
		cur_test = "reset";
		load_programs();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check_value("reset pair_rdy", 32'd1, o_pair_rdy);
		check_value("reset wb0_vld", 32'd0, o_wb0_vld);
		check_value("reset wb1_vld", 32'd0, o_wb1_vld);
		@(posedge clk);
		for (int t = 0; t < test_name.size(); t++) begin
			run_test(t);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// 40 cycles per instruction in the table
	initial begin
		wait (loaded);
		repeat (40 * 2 * pair_q.size() + 20) @(posedge clk);
		$display("timeout in test %s: the run did not finish in time, errors so far: %0d",
			cur_test, errors);
		$display("Regression failed");
		$finish;
	end

endmodule

/* issue/issue_window.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module issue_window import core_pkg::*; (
	input  logic                    clk,
	input  logic                    rstn,
	decoded_if.win                  dec,
	issue_if.win                    lane0,
	issue_if.win                    lane1,
	input  logic [`NUM_REGS-1:0]    i_pending,
	output logic [`ISSUE_LANES-1:0] o_set_vld,
	output logic [`REG_ADDR_W-1:0]  o_set_addr [`ISSUE_LANES]
);

	instr_t                   slot [`WINDOW_SLOTS];
	logic [`WINDOW_SLOTS-1:0] slot_vld;
	logic [`REG_ADDR_W-1:0]   src1 [`WINDOW_SLOTS];
	logic [`REG_ADDR_W-1:0]   src2 [`WINDOW_SLOTS];
	logic [`REG_ADDR_W-1:0]   dst [`WINDOW_SLOTS];
	logic [`WINDOW_SLOTS-1:0] elig;
	logic [`WINDOW_SLOTS-1:0] issued;
	logic [`WINDOW_SLOTS-1:0] remain;
	logic [1:0]               sel [`ISSUE_LANES];
	instr_t                   nxt [`WINDOW_SLOTS];
	logic [`WINDOW_SLOTS-1:0] nxt_vld;

	// r0 never causes a hazard
	function automatic logic same_reg(input logic [`REG_ADDR_W-1:0] a,
			input logic [`REG_ADDR_W-1:0] b);
		return (a != '0) && (a == b);
	endfunction

	// fields actually read, by format
	always_comb begin
		for (int k = 0; k < `WINDOW_SLOTS; k++) begin
			dst[k] = slot[k].r.rd;
			src1[k] = (slot[k].i.opc == `OPC_LUI) ? '0 : slot[k].i.rs;
			src2[k] = opc_is_imm(slot[k].r.opc) ? '0 : slot[k].r.rs2;
		end
	end

	always_comb begin
		for (int k = 0; k < `WINDOW_SLOTS; k++) begin
			elig[k] = slot_vld[k] && !i_pending[src1[k]] && !i_pending[src2[k]] &&
				!i_pending[dst[k]];
			// raw, waw and war against every older entry
			for (int j = 0; j < k; j++) begin
				if (slot_vld[j] && (same_reg(dst[j], src1[k]) || same_reg(dst[j], src2[k]) ||
						same_reg(dst[j], dst[k]) || same_reg(dst[k], src1[j]) ||
						same_reg(dst[k], src2[j]))) begin
					elig[k] = 1'b0;
				end
			end
		end
	end

	// oldest eligible to lane 0, next to lane 1
	always_comb begin
		int n;
		n = 0;
		issued = '0;
		o_set_vld = '0;
		for (int l = 0; l < `ISSUE_LANES; l++) begin
			sel[l] = '0;
		end
		for (int k = 0; k < `WINDOW_SLOTS; k++) begin
			if (elig[k] && n < `ISSUE_LANES) begin
				sel[n] = 2'(k);
				o_set_vld[n] = 1'b1;
				issued[k] = 1'b1;
				n++;
			end
		end
		for (int l = 0; l < `ISSUE_LANES; l++) begin
			o_set_addr[l] = o_set_vld[l] ? dst[sel[l]] : '0;
		end
	end

	assign lane0.vld = o_set_vld[0];
	assign lane0.instr = slot[sel[0]];
	assign lane0.dest = o_set_addr[0];
	assign lane1.vld = o_set_vld[1];
	assign lane1.instr = slot[sel[1]];
	assign lane1.dest = o_set_addr[1];

	assign remain = slot_vld & ~issued;
	assign dec.busy = $countones(remain) >= 2;

	// shift leftovers forward, then append the decoded pair
	always_comb begin
		int n;
		n = 0;
		nxt_vld = '0;
		nxt = slot;
		for (int k = 0; k < `WINDOW_SLOTS; k++) begin
			if (remain[k]) begin
				nxt[n] = slot[k];
				nxt_vld[n] = 1'b1;
				n++;
			end
		end
		if (!dec.busy) begin
			for (int d = 0; d < `ISSUE_LANES; d++) begin
				if (dec.vld[d] && n < `WINDOW_SLOTS) begin
					nxt[n] = dec.instr[d];
					nxt_vld[n] = 1'b1;
					n++;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			slot_vld <= '0;
		end else begin
			slot_vld <= nxt_vld;
		end
	end

	always_ff @(posedge clk) begin
		slot <= nxt;
	end

endmodule

/* issue/scoreboard.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module scoreboard (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic [`ISSUE_LANES-1:0] i_set_vld,
	input  logic [`REG_ADDR_W-1:0]  i_set_addr [`ISSUE_LANES],
	input  logic                    i_wb0_vld,
	input  logic [`REG_ADDR_W-1:0]  i_wb0_addr,
	input  logic                    i_wb1_vld,
	input  logic [`REG_ADDR_W-1:0]  i_wb1_addr,
	output logic [`NUM_REGS-1:0]    o_pending
);

	logic [`NUM_REGS-1:0] pend_nxt;

	always_comb begin
		pend_nxt = o_pending;
		if (i_wb0_vld) begin
			pend_nxt[i_wb0_addr] = 1'b0;
		end
		if (i_wb1_vld) begin
			pend_nxt[i_wb1_addr] = 1'b0;
		end
		// set wins over clear
		for (int l = 0; l < `ISSUE_LANES; l++) begin
			if (i_set_vld[l]) begin
				pend_nxt[i_set_addr[l]] = 1'b1;
			end
		end
		pend_nxt[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_pending <= '0;
		end else begin
			o_pending <= pend_nxt;
		end
	end

endmodule

/* src/alu_lane.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module alu_lane import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rstn,
	issue_if.lane                  iss,
	output logic [`REG_ADDR_W-1:0] o_rd_addr [2],
	input  logic [`XLEN-1:0]       i_rd_data [2],
	output logic                   o_wb_vld,
	output logic [`REG_ADDR_W-1:0] o_wb_addr,
	output logic [`XLEN-1:0]       o_wb_data
);

	logic [`IMM_W-1:0]      imm;
	logic [`XLEN-1:0]       imm_ext;
	logic                   ex_vld;
	logic [`OPC_W-1:0]      ex_opc;
	logic [`REG_ADDR_W-1:0] ex_dest;
	logic [`XLEN-1:0]       ex_a;
	logic [`XLEN-1:0]       ex_b;
	logic [`XLEN-1:0]       result;

	assign o_rd_addr[0] = iss.instr.r.rs1;
	assign o_rd_addr[1] = iss.instr.r.rs2;
	assign imm = iss.instr.i.imm;

	always_comb begin
		case (iss.instr.i.opc)
			`OPC_ADDI: imm_ext = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
			`OPC_LUI:  imm_ext = {imm, {(`XLEN-`IMM_W){1'b0}}};
			default:   imm_ext = {{(`XLEN-`IMM_W){1'b0}}, imm};
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ex_vld <= 1'b0;
			o_wb_vld <= 1'b0;
		end else begin
			ex_vld <= iss.vld;
			o_wb_vld <= ex_vld && (ex_dest != '0);
		end
	end

	// operands captured on issue
	always_ff @(posedge clk) begin
		if (iss.vld) begin
			ex_opc <= iss.instr.r.opc;
			ex_dest <= iss.dest;
			ex_a <= i_rd_data[0];
			ex_b <= opc_is_imm(iss.instr.r.opc) ? imm_ext : i_rd_data[1];
		end
	end

	always_comb begin
		case (ex_opc)
			`OPC_ADD, `OPC_ADDI: result = ex_a + ex_b;
			`OPC_SUB:            result = ex_a - ex_b;
			`OPC_AND:            result = ex_a & ex_b;
			`OPC_OR, `OPC_ORI:   result = ex_a | ex_b;
			`OPC_XOR:            result = ex_a ^ ex_b;
			`OPC_SLT:            result = {{(`XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
			`OPC_LUI:            result = ex_b;
			default:             result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ex_vld) begin
			o_wb_addr <= ex_dest;
			o_wb_data <= result;
		end
	end

endmodule

/* src/cpu_core.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module cpu_core (
	input  logic                   clk,
	input  logic                   rstn,
	output logic                   o_pair_rdy,
	input  logic                   i_pair_vld,
	input  logic [2*`XLEN-1:0]     i_pair,
	output logic                   o_wb0_vld,
	output logic [`REG_ADDR_W-1:0] o_wb0_addr,
	output logic [`XLEN-1:0]       o_wb0_data,
	output logic                   o_wb1_vld,
	output logic [`REG_ADDR_W-1:0] o_wb1_addr,
	output logic [`XLEN-1:0]       o_wb1_data
);

	decoded_if dec_bus ();
	issue_if   iss0 ();
	issue_if   iss1 ();

	logic [`NUM_REGS-1:0]    pending;
	logic [`ISSUE_LANES-1:0] set_vld;
	logic [`REG_ADDR_W-1:0]  set_addr [`ISSUE_LANES];
	logic [`REG_ADDR_W-1:0]  lane0_rd_addr [2];
	logic [`REG_ADDR_W-1:0]  lane1_rd_addr [2];
	logic [`XLEN-1:0]        lane0_rd_data [2];
	logic [`XLEN-1:0]        lane1_rd_data [2];
	logic [`REG_ADDR_W-1:0]  rd_addr [4];
	logic [`XLEN-1:0]        rd_data [4];

	// read ports 0-1 serve lane 0, 2-3 lane 1
	assign rd_addr = '{lane0_rd_addr[0], lane0_rd_addr[1], lane1_rd_addr[0], lane1_rd_addr[1]};
	assign lane0_rd_data = '{rd_data[0], rd_data[1]};
	assign lane1_rd_data = '{rd_data[2], rd_data[3]};

	pair_decoder u_dec (
		.clk        (clk),
		.rstn       (rstn),
		.i_pair_vld (i_pair_vld),
		.i_pair     (i_pair),
		.o_pair_rdy (o_pair_rdy),
		.dec        (dec_bus.dec)
	);

	issue_window u_win (
		.clk        (clk),
		.rstn       (rstn),
		.dec        (dec_bus.win),
		.lane0      (iss0.win),
		.lane1      (iss1.win),
		.i_pending  (pending),
		.o_set_vld  (set_vld),
		.o_set_addr (set_addr)
	);

	scoreboard u_sb (
		.clk        (clk),
		.rstn       (rstn),
		.i_set_vld  (set_vld),
		.i_set_addr (set_addr),
		.i_wb0_vld  (o_wb0_vld),
		.i_wb0_addr (o_wb0_addr),
		.i_wb1_vld  (o_wb1_vld),
		.i_wb1_addr (o_wb1_addr),
		.o_pending  (pending)
	);

	reg_file u_rf (
		.clk        (clk),
		.i_rd_addr  (rd_addr),
		.o_rd_data  (rd_data),
		.i_wb0_vld  (o_wb0_vld),
		.i_wb0_addr (o_wb0_addr),
		.i_wb0_data (o_wb0_data),
		.i_wb1_vld  (o_wb1_vld),
		.i_wb1_addr (o_wb1_addr),
		.i_wb1_data (o_wb1_data)
	);

	alu_lane lane0 (
		.clk       (clk),
		.rstn      (rstn),
		.iss       (iss0.lane),
		.o_rd_addr (lane0_rd_addr),
		.i_rd_data (lane0_rd_data),
		.o_wb_vld  (o_wb0_vld),
		.o_wb_addr (o_wb0_addr),
		.o_wb_data (o_wb0_data)
	);

	alu_lane lane1 (
		.clk       (clk),
		.rstn      (rstn),
		.iss       (iss1.lane),
		.o_rd_addr (lane1_rd_addr),
		.i_rd_data (lane1_rd_data),
		.o_wb_vld  (o_wb1_vld),
		.o_wb_addr (o_wb1_addr),
		.o_wb_data (o_wb1_data)
	);

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module reg_file (
	input  logic                   clk,
	input  logic [`REG_ADDR_W-1:0] i_rd_addr [4],
	output logic [`XLEN-1:0]       o_rd_data [4],
	input  logic                   i_wb0_vld,
	input  logic [`REG_ADDR_W-1:0] i_wb0_addr,
	input  logic [`XLEN-1:0]       i_wb0_data,
	input  logic                   i_wb1_vld,
	input  logic [`REG_ADDR_W-1:0] i_wb1_addr,
	input  logic [`XLEN-1:0]       i_wb1_data
);

	logic [`XLEN-1:0] mem [`NUM_REGS];

	// no forwarding, reads see last edge's contents
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			o_rd_data[p] = (i_rd_addr[p] == '0) ? '0 : mem[i_rd_addr[p]];
		end
	end

	always_ff @(posedge clk) begin
		if (i_wb0_vld) begin
			mem[i_wb0_addr] <= i_wb0_data;
		end
		if (i_wb1_vld) begin
			mem[i_wb1_addr] <= i_wb1_data;
		end
	end

endmodule

/* verilog.f */
+incdir+common
+incdir+dv
common/core_pkg.sv
common/decoded_if.sv
common/issue_if.sv
decode/pair_decoder.sv
issue/scoreboard.sv
issue/issue_window.sv
src/reg_file.sv
src/alu_lane.sv
src/cpu_core.sv
dv/tb_cpu_core.sv
